//--- include/font_glyphs.svh
// Hex digit glyphs 0 to F, 8x8; include once inside each module body that needs them.
// Row 0 sits in bits 63:56 and the left pixel of a row is its top bit.

// Glyph bit for row r and column c is at index 63 - 8*r - c.
localparam logic [0:15][63:0] font_glyphs = '{
    64'h3C666E7666663C00,
    64'h183818181818_7E00,
    64'h3C66060C30607E00,
    64'h3C66061C06663C00,
    64'h0C1C3C6C7E0C0C00,
    64'h7E607C0606663C00,
    64'h3C607C6666663C00,
    64'h7E060C1830303000,
    64'h3C66663C66663C00,
    64'h3C66663E060C3800,
    64'h183C66667E666600,
    64'h7C66667C66667C00,
    64'h3C66606060663C00,
    64'h786C6666666C7800,
    64'h7E60607C60607E00,
    64'h7E60607C60606000
};

//--- logic/display_pkg.sv
// Geometry of the small test panel, text grid and display-side types.
// Blanking follows the active area on each line and after the last line.
`default_nettype none

package display_pkg;

    // Visible area in pixels.
    localparam int h_active = 64;
    localparam int v_active = 24;

    // Horizontal blanking in ticks.
    localparam int h_front = 2;
    localparam int h_sync  = 4;
    localparam int h_back  = 2;

    // Vertical blanking in lines.
    localparam int v_front = 1;
    localparam int v_sync  = 2;
    localparam int v_back  = 1;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // Text grid of 8x8 cells, one debug word per row.
    localparam int glyph_size   = 8;
    localparam int text_columns = 8;
    localparam int text_rows    = 3;

    // Foreground red for the overlay.
    localparam logic [7:0] overlay_red = 8'h80;

    typedef logic [6:0] x_t;
    typedef logic [4:0] y_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    typedef struct packed {
        pixel_t pixel;
        logic   data_enable;
        logic   hs_n;
        logic   vs_n;
        logic   pixel_clock;
    } lcd_out_t;

    // Switch inputs.
    typedef struct packed {
        logic overlay_enable;
        logic force_hs_high;
        logic force_vs_high;
    } control_t;

    typedef struct packed {
        logic [31:0] value0;
        logic [31:0] value1;
        logic [31:0] value2;
    } debug_words_t;

endpackage

`default_nettype wire

//--- logic/memory_pkg.sv
// Frame-buffer placement and read-port types; addresses count 64-bit words.
// The frame buffer must be a whole number of bursts long.
`default_nettype none

package memory_pkg;

    // Byte address 0x3800_0000 in 64-bit words.
    localparam logic [28:0] fb_base = 29'h0700_0000;
    localparam int pixels_per_word = 2;
    // Whole 64x24 panel.
    localparam int fb_words = 64 * 24 / pixels_per_word;
    localparam int burst_words = 8;
    localparam int fifo_depth_words = 32;

    typedef logic [28:0] word_addr_t;
    typedef logic [$clog2(fb_words + 1)-1:0] word_count_t;
    typedef logic [$clog2(fifo_depth_words)-1:0] fifo_ptr_t;
    typedef logic [$clog2(fifo_depth_words + 1)-1:0] fifo_count_t;
    typedef logic [$clog2(burst_words + 1)-1:0] beat_count_t;

    typedef struct packed {
        word_addr_t address;
        logic [7:0] burstcount;
        logic       read;
    } mem_request_t;

    typedef struct packed {
        logic        waitrequest;
        logic [63:0] readdata;
        logic        readdatavalid;
    } mem_response_t;

endpackage

`default_nettype wire

//--- logic/lcd_timing.sv
// Panel timing at half of clock_50; every output holds for two clocks.
// Active area comes first on each line, so the frame starts with an active line.
`timescale 1ns/10ps
`default_nettype none

module lcd_timing (
    input  logic            clock_50,
    input  logic            reset,
    output logic            tick,
    output display_pkg::x_t x,
    output display_pkg::y_t y,
    output logic            data_enable,
    output logic            hs_n,
    output logic            vs_n,
    output logic            next_frame
);
    import display_pkg::*;

    // Low until the first tick, which then shows pixel (0, 0).
    logic started;
    x_t   x_next;
    y_t   y_next;
    logic line_end;
    logic frame_end;

    assign line_end  = x == x_t'(h_total - 1);
    assign frame_end = line_end && y == y_t'(v_total - 1);

    // One clock wide, on the tick that leaves the last active line.
    // The reader then refills its FIFO over the vertical blanking.
    assign next_frame = tick && started && line_end && y == y_t'(v_active - 1);

    // Position for the coming tick.
    always_comb begin
        x_next = x;
        y_next = y;
        if (started) begin
            if (line_end) begin
                x_next = '0;
                y_next = frame_end ? '0 : y + 1'b1;
            end else begin
                x_next = x + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_50) begin
        if (reset) begin
            tick        <= 1'b0;
            started     <= 1'b0;
            x           <= '0;
            y           <= '0;
            data_enable <= 1'b0;
            hs_n        <= 1'b1;
            vs_n        <= 1'b1;
        end else begin
            // 25 MHz.
            tick <= !tick;
            if (tick) begin
                started <= 1'b1;
                x       <= x_next;
                y       <= y_next;
                // Decodes follow the new position.
                data_enable <= x_next < x_t'(h_active) && y_next < y_t'(v_active);
                hs_n <= !(x_next >= x_t'(h_active + h_front)
                          && x_next < x_t'(h_active + h_front + h_sync));
                vs_n <= !(y_next >= y_t'(v_active + v_front)
                          && y_next < y_t'(v_active + v_front + v_sync));
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/scanout_reader.sv
// Reads the frame buffer at fb_base in bursts, one burst in flight at a time.
// An empty FIFO on an active tick gives a black pixel and sets underrun until next_frame.
`timescale 1ns/10ps
`default_nettype none

module scanout_reader (
    input  logic                      clock_50,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      data_enable,
    input  logic                      next_frame,
    output memory_pkg::mem_request_t  mem_request,
    input  memory_pkg::mem_response_t mem_response,
    output display_pkg::pixel_t       pixel,
    output logic                      underrun
);
    import display_pkg::*;
    import memory_pkg::*;

    logic [63:0] fifo_mem [fifo_depth_words];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    // Next pixel comes from the upper half of the head word.
    logic        upper_half;
    word_addr_t  address;
    word_count_t words_left;
    logic        req_read;
    beat_count_t beats_left;
    // Burst data from before next_frame, still to be drained.
    logic        stale;
    logic        accept;
    logic        issue;
    logic        push;
    logic        pop;
    logic        pop_word;

    // Red in the low byte, blue in the high byte.
    function automatic pixel_t unpack(input logic [23:0] bits);
        pixel_t p;
        p.red   = bits[7:0];
        p.green = bits[15:8];
        p.blue  = bits[23:16];
        return p;
    endfunction

    assign accept = req_read && !mem_response.waitrequest;
    // Room for a whole burst, and nothing in flight.
    assign issue = !next_frame && !req_read && beats_left == '0 && words_left != '0
                   && count <= fifo_count_t'(fifo_depth_words - burst_words);
    assign push     = mem_response.readdatavalid && !stale;
    assign pop      = tick && data_enable;
    assign pop_word = pop && upper_half && count != '0;

    assign mem_request = '{address: address, burstcount: 8'(burst_words), read: req_read};

    // Burst requests.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            address    <= fb_base;
            words_left <= word_count_t'(fb_words);
            req_read   <= 1'b0;
            beats_left <= '0;
            stale      <= 1'b0;
        end else begin
            if (mem_response.readdatavalid && beats_left != '0) begin
                beats_left <= beats_left - 1'b1;
            end
            if (accept) begin
                req_read <= 1'b0;
            end
            if (next_frame) begin
                address    <= fb_base;
                words_left <= word_count_t'(fb_words);
                stale      <= req_read || beats_left != '0;
            end else if (accept) begin
                address    <= address + word_addr_t'(burst_words);
                words_left <= words_left - word_count_t'(burst_words);
            end else if (issue) begin
                req_read   <= 1'b1;
                beats_left <= beat_count_t'(burst_words);
                stale      <= 1'b0;
            end
        end
    end

    // FIFO pointers and underrun; depth is a power of two so pointers wrap.
    always_ff @(posedge clock_50) begin
        if (reset || next_frame) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            upper_half <= 1'b0;
            underrun   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_word) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_count_t'(push) - fifo_count_t'(pop_word);
            if (pop) begin
                if (count == '0) begin
                    underrun <= 1'b1;
                end else begin
                    upper_half <= !upper_half;
                end
            end
        end
    end

    // Word storage and pixel out, one tick behind data_enable.
    always_ff @(posedge clock_50) begin
        if (push) begin
            fifo_mem[wr_ptr] <= mem_response.readdata;
        end
        if (pop) begin
            if (count == '0) begin
                pixel <= '0;
            end else if (upper_half) begin
                pixel <= unpack(fifo_mem[rd_ptr][55:32]);
            end else begin
                pixel <= unpack(fifo_mem[rd_ptr][23:0]);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/text_overlay.sv
// Hex dump of three debug words, one per text row, at 8x8 cells from the top left.
// glyph_on is one tick behind x and y.
`timescale 1ns/10ps
`default_nettype none

module text_overlay (
    input  logic                      clock_50,
    input  logic                      tick,
    input  display_pkg::x_t           x,
    input  display_pkg::y_t           y,
    input  display_pkg::debug_words_t debug_words,
    output logic                      glyph_on
);
    import display_pkg::*;

    `include "font_glyphs.svh"

    // Text cell, 0 to 8 across and 0 to 3 down.
    logic [3:0]  column;
    logic [1:0]  row;
    // Pixel inside the cell.
    logic [2:0]  glyph_x;
    logic [2:0]  glyph_y;
    logic [2:0]  digit_index;
    logic [31:0] word;
    logic [3:0]  digit;
    logic        in_grid;
    logic        glyph_bit;

    assign column  = 4'(x / glyph_size);
    assign row     = 2'(y / glyph_size);
    assign glyph_x = 3'(x % glyph_size);
    assign glyph_y = 3'(y % glyph_size);
    assign in_grid = column < 4'(text_columns) && row < 2'(text_rows);

    // Most significant digit in column 0.
    assign digit_index = 3'(text_columns - 1) - column[2:0];

    always_comb begin
        case (row)
            2'd0:    word = debug_words.value0;
            2'd1:    word = debug_words.value1;
            default: word = debug_words.value2;
        endcase
    end

    assign digit     = word[{digit_index, 2'b00} +: 4];
    assign glyph_bit = font_glyphs[digit][~{glyph_y, glyph_x}];

    always_ff @(posedge clock_50) begin
        if (tick) begin
            glyph_on <= in_grid && glyph_bit;
        end
    end

endmodule

`default_nettype wire

//--- logic/lcd_top.sv
// LCD path: timing, frame-buffer scan-out and hex overlay, outputs registered in clock_50.
// pixel_clock is the 25 MHz tick, one clock late like the rest of lcd_out.
`timescale 1ns/10ps
`default_nettype none

module lcd_top (
    input  logic                      clock_50,
    input  logic                      reset,
    output memory_pkg::mem_request_t  mem_request,
    input  memory_pkg::mem_response_t mem_response,
    input  display_pkg::control_t     control,
    input  display_pkg::debug_words_t debug_words,
    output display_pkg::lcd_out_t     lcd_out,
    output logic                      underrun
);
    import display_pkg::*;

    logic     tick;
    x_t       x;
    y_t       y;
    logic     data_enable;
    logic     hs_n;
    logic     vs_n;
    logic     next_frame;
    pixel_t   fb_pixel;
    logic     glyph_on;
    // Timing delayed one tick to line up with the pixel.
    logic     data_enable_d;
    logic     hs_n_d;
    logic     vs_n_d;
    lcd_out_t lcd_next;

    lcd_timing timing0 (
        .clock_50    (clock_50),
        .reset       (reset),
        .tick        (tick),
        .x           (x),
        .y           (y),
        .data_enable (data_enable),
        .hs_n        (hs_n),
        .vs_n        (vs_n),
        .next_frame  (next_frame)
    );

    scanout_reader reader0 (
        .clock_50     (clock_50),
        .reset        (reset),
        .tick         (tick),
        .data_enable  (data_enable),
        .next_frame   (next_frame),
        .mem_request  (mem_request),
        .mem_response (mem_response),
        .pixel        (fb_pixel),
        .underrun     (underrun)
    );

    text_overlay overlay0 (
        .clock_50    (clock_50),
        .tick        (tick),
        .x           (x),
        .y           (y),
        .debug_words (debug_words),
        .glyph_on    (glyph_on)
    );

    always_ff @(posedge clock_50) begin
        if (reset) begin
            data_enable_d <= 1'b0;
            hs_n_d        <= 1'b1;
            vs_n_d        <= 1'b1;
        end else if (tick) begin
            data_enable_d <= data_enable;
            hs_n_d        <= hs_n;
            vs_n_d        <= vs_n;
        end
    end

    // Overlay colour and sync forcing from the switches.
    always_comb begin
        lcd_next.pixel = fb_pixel;
        if (glyph_on && control.overlay_enable) begin
            lcd_next.pixel = '{red: overlay_red, green: 8'h00, blue: 8'h00};
        end
        lcd_next.data_enable = data_enable_d;
        lcd_next.hs_n        = hs_n_d || control.force_hs_high;
        lcd_next.vs_n        = vs_n_d || control.force_vs_high;
        lcd_next.pixel_clock = tick;
    end

    // Clean output.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            lcd_out <= '{pixel: '0, data_enable: 1'b0, hs_n: 1'b1, vs_n: 1'b1,
                         pixel_clock: 1'b0};
        end else begin
            lcd_out <= lcd_next;
        end
    end

endmodule

`default_nettype wire

//--- tests/memory_model.sv
// Read-port responder for the frame buffer; word data depends only on the address.
// Stall mode adds random waitrequest and 1 to 6 cycles of read latency.
`timescale 1ns/10ps
`default_nettype none

module memory_model (
    input  logic                      clock_50,
    input  logic                      reset,
    input  logic                      stall_mode,
    input  memory_pkg::mem_request_t  mem_request,
    output memory_pkg::mem_response_t mem_response
);
    import memory_pkg::*;

    integer      seed = 32'h7d67;
    word_addr_t  next_address;
    int unsigned beats_left;
    // Cycles still to wait before the first beat.
    int unsigned delay;

    // Red, green and blue from the index, top byte keeps the high index bits.
    // Blue also folds in the top byte, which carries the high address bits.
    function automatic logic [31:0] half_word(input logic [31:0] p);
        return {p[31:24], p[31:24] ^ p[23:16] ^ p[7:0], p[15:8], p[7:0]};
    endfunction

    // Even pixel index in the low half.
    function automatic logic [63:0] pattern_word(input word_addr_t address);
        logic [31:0] index;
        index = 32'(address - fb_base) << 1;
        return {half_word(index | 32'd1), half_word(index)};
    endfunction

    always @(posedge clock_50) begin
        mem_response.readdatavalid <= 1'b0;
        mem_response.waitrequest   <= stall_mode ? 1'($random(seed)) : 1'b0;
        if (reset) begin
            beats_left = 0;
            delay = 0;
        end else begin
            // New burst only once the last one has returned.
            if (beats_left == 0 && mem_request.read && !mem_response.waitrequest) begin
                next_address = mem_request.address;
                beats_left = 32'(mem_request.burstcount);
                delay = stall_mode ? $unsigned($random(seed)) % 6 : 0;
            end
            // Zero delay puts the first beat in the cycle after acceptance.
            if (beats_left != 0) begin
                if (delay != 0) begin
                    delay = delay - 1;
                end else begin
                    mem_response.readdatavalid <= 1'b1;
                    mem_response.readdata      <= pattern_word(next_address);
                    next_address = next_address + word_addr_t'(1);
                    beats_left = beats_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_lcd_top.sv
// Directed tests of the LCD path against the read-port memory model.
// Pixels are sampled once per tick, where lcd_out.pixel_clock is high.
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_top;
    import display_pkg::*;
    import memory_pkg::*;

    `include "font_glyphs.svh"

    localparam int frame_clocks = 2 * h_total * v_total;
    localparam int frame_pixels = h_active * v_active;

    logic          clock_50 = 1'b0;
    logic          reset;
    logic          stall_mode;
    control_t      control;
    debug_words_t  debug_words;
    mem_request_t  mem_request;
    mem_response_t mem_response;
    lcd_out_t      lcd_out;
    logic          underrun;
    int            errors = 0;
    int            failed_tests = 0;
    int            test_count = 0;

    lcd_top dut0 (
        .clock_50     (clock_50),
        .reset        (reset),
        .mem_request  (mem_request),
        .mem_response (mem_response),
        .control      (control),
        .debug_words  (debug_words),
        .lcd_out      (lcd_out),
        .underrun     (underrun)
    );

    memory_model memory0 (
        .clock_50     (clock_50),
        .reset        (reset),
        .stall_mode   (stall_mode),
        .mem_request  (mem_request),
        .mem_response (mem_response)
    );

    always #5 clock_50 = !clock_50;

    // Rising edge, then 1 ns.
    task automatic step();
        @(posedge clock_50);
        #1;
    endtask

    task automatic compare_pixel(input pixel_t actual, input pixel_t expected,
                                 input string what);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic compare_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int start);
        test_count++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    // Memory fill formula, per pixel index.
    function automatic pixel_t frame_pixel(input int index);
        logic [31:0] p;
        pixel_t      px;
        p = 32'(index);
        px.red   = p[7:0];
        px.green = p[15:8];
        px.blue  = p[31:24] ^ p[23:16] ^ p[7:0];
        return px;
    endfunction

    // Hex digit of the row's word, most significant digit leftmost.
    function automatic pixel_t expected_pixel(input int index, input logic overlay);
        int          x;
        int          y;
        int          bit_index;
        logic [31:0] word;
        logic [3:0]  digit;
        x = index % h_active;
        y = index / h_active;
        case (y / glyph_size)
            0:       word = debug_words.value0;
            1:       word = debug_words.value1;
            default: word = debug_words.value2;
        endcase
        digit = 4'(word >> (4 * (text_columns - 1 - x / glyph_size)));
        bit_index = 63 - glyph_size * (y % glyph_size) - x % glyph_size;
        if (overlay && y / glyph_size < text_rows && x / glyph_size < text_columns
            && font_glyphs[digit][6'(bit_index)]) begin
            return '{red: overlay_red, green: 8'h00, blue: 8'h00};
        end
        return frame_pixel(index);
    endfunction

    task automatic wait_vs_fall();
        logic previous;
        int   guard;
        guard = 0;
        do begin
            previous = lcd_out.vs_n;
            step();
            guard++;
        end while (!(previous && !lcd_out.vs_n) && guard < 2 * frame_clocks);
        if (!(previous && !lcd_out.vs_n)) begin
            errors++;
            $display("Timed out waiting for vs_n to fall at %0d ns", $time);
        end
    endtask

    // One frame of active pixels; stops at the first wrong one.
    task automatic check_frame(input logic overlay);
        int index;
        int guard;
        int errors_before;
        index = 0;
        guard = 0;
        errors_before = errors;
        while (index < frame_pixels && errors == errors_before && guard < frame_clocks) begin
            step();
            guard++;
            if (lcd_out.pixel_clock && lcd_out.data_enable) begin
                compare_pixel(lcd_out.pixel, expected_pixel(index, overlay),
                              $sformatf("pixel %0d", index));
                index++;
            end
        end
        if (errors == errors_before && index < frame_pixels) begin
            errors++;
            $display("Timed out after %0d of %0d pixels", index, frame_pixels);
        end
        compare_flag(underrun, 1'b0, "underrun");
    endtask

    task automatic count_low_clocks(input logic watch_vs, output int lows);
        lows = 0;
        repeat (frame_clocks) begin
            step();
            if (watch_vs ? !lcd_out.vs_n : !lcd_out.hs_n) begin
                lows++;
            end
        end
    endtask

    // Outputs still hold their reset values.
    task automatic reset_state();
        int start;
        start = errors;
        compare_flag(lcd_out.data_enable, 1'b0, "data_enable after reset");
        compare_flag(lcd_out.hs_n, 1'b1, "hs_n after reset");
        compare_flag(lcd_out.vs_n, 1'b1, "vs_n after reset");
        compare_flag(mem_request.read, 1'b0, "read after reset");
        compare_flag(underrun, 1'b0, "underrun after reset");
        finish_test("reset state", start);
    endtask

    // Lines counted by hs_n falls from one vs_n fall to the next.
    task automatic frame_geometry();
        int   start;
        int   lines;
        int   active_lines;
        int   de_ticks;
        int   low_run;
        int   guard;
        logic previous_hs;
        logic previous_vs;
        start = errors;
        lines = 0;
        active_lines = 0;
        de_ticks = 0;
        low_run = 0;
        guard = 0;
        wait_vs_fall();
        do begin
            previous_hs = lcd_out.hs_n;
            previous_vs = lcd_out.vs_n;
            step();
            guard++;
            if (lcd_out.pixel_clock && lcd_out.data_enable) begin
                de_ticks++;
            end
            if (!lcd_out.hs_n) begin
                low_run++;
            end else if (low_run != 0) begin
                compare_count(low_run, 2 * h_sync, "hs_n low clocks");
                low_run = 0;
            end
            // Blank lines hold no enabled ticks at all.
            if (previous_hs && !lcd_out.hs_n) begin
                lines++;
                if (de_ticks != 0) begin
                    compare_count(de_ticks, h_active, "enabled ticks in line");
                    active_lines++;
                end
                de_ticks = 0;
            end
        end while (!(previous_vs && !lcd_out.vs_n) && guard < 2 * frame_clocks);
        if (!(previous_vs && !lcd_out.vs_n)) begin
            errors++;
            $display("Timed out waiting for the next vs_n fall");
        end
        compare_count(lines, v_total, "lines per frame");
        compare_count(active_lines, v_active, "active lines per frame");
        finish_test("frame geometry", start);
    endtask

    task automatic plain_scanout();
        int start;
        start = errors;
        stall_mode = 1'b0;
        control = '0;
        wait_vs_fall();
        check_frame(1'b0);
        finish_test("plain scan-out", start);
    endtask

    // Digits 0 to F all appear over the three rows.
    task automatic overlay_text();
        int start;
        start = errors;
        debug_words = '{value0: 32'h0123_4567, value1: 32'h89ab_cdef, value2: 32'hc0de_f00d};
        control = '{overlay_enable: 1'b1, force_hs_high: 1'b0, force_vs_high: 1'b0};
        wait_vs_fall();
        check_frame(1'b1);
        control = '0;
        finish_test("text overlay", start);
    endtask

    task automatic back_pressure();
        int start;
        start = errors;
        stall_mode = 1'b1;
        repeat (2) begin
            wait_vs_fall();
            check_frame(1'b0);
        end
        stall_mode = 1'b0;
        finish_test("back-pressure", start);
    endtask

    task automatic sync_forcing();
        int start;
        int lows;
        start = errors;
        control = '{overlay_enable: 1'b0, force_hs_high: 1'b1, force_vs_high: 1'b0};
        count_low_clocks(1'b0, lows);
        compare_count(lows, 0, "hs_n low clocks while forced");
        control = '{overlay_enable: 1'b0, force_hs_high: 1'b0, force_vs_high: 1'b1};
        count_low_clocks(1'b1, lows);
        compare_count(lows, 0, "vs_n low clocks while forced");
        control = '0;
        finish_test("sync forcing", start);
    endtask

    initial begin
        reset = 1'b1;
        stall_mode = 1'b0;
        control = '0;
        debug_words = '0;
        repeat (16) @(posedge clock_50);
        #1;
        reset = 1'b0;
        reset_state();
        frame_geometry();
        plain_scanout();
        overlay_text();
        back_pressure();
        sync_forcing();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
logic/display_pkg.sv
logic/memory_pkg.sv
logic/lcd_timing.sv
logic/scanout_reader.sv
logic/text_overlay.sv
logic/lcd_top.sv
tests/memory_model.sv
tests/tb_lcd_top.sv

//--- Makefile
# Verilator simulation of the LCD display path.
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= PASS: all tests
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
